/* list.f */
logic/csr_pkg.sv
logic/csr_access_decode.sv
logic/csr_trap_regs.sv
logic/csr_perf_counters.sv
logic/csr_file_top.sv
sim/csr_file_checker.sv
sim/csr_file_tb.sv

/* Makefile */
# Verilator build and run for the CSR file testbench

VERILATOR ?= verilator
TOP       ?= csr_file_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run FAILED"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "run FAILED, no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/csr_file_tb.sv */
/*
 * testbench for the machine-mode CSR file
 * reference model, procedural checks, watchdog
 */
`timescale 1ns/100ps

module csr_file_tb;

  localparam int unsigned  CLK_PERIOD     = 20;
  localparam int unsigned  STIM_CYCLES    = 660;             // rough length of all tests
  localparam int unsigned  TIMEOUT_CYCLES = 3 * STIM_CYCLES; // about 2000
  localparam logic [31:0]  SEED_INIT      = 32'h8afd6163;

  logic                clk_i = 1'b0;
  logic                rst_ni;
  logic [3:0]          core_id_i;
  logic [5:0]          cluster_id_i;
  logic                csr_access_i, is_decoding_i;
  csr_pkg::csr_addr_t  csr_addr_i;
  csr_pkg::xlen_t      csr_wdata_i, pc_if_i, pc_id_i, csr_mtval_i, csr_mtvec_i;
  csr_pkg::csr_op_e    csr_op_i;
  logic                csr_save_if_i, csr_save_id_i, csr_save_cause_i, csr_restore_mret_i;
  csr_pkg::exc_cause_t csr_mcause_i;
  logic                insn_ret_i;
  csr_pkg::xlen_t      csr_rdata_o, csr_mepc_o;
  logic                illegal_csr_insn_o, m_irq_enable_o;

  integer         seed = SEED_INIT;
  int unsigned    errors = 0;
  int unsigned    checks = 0;
  // reference model state
  logic           m_mie, m_mpie;
  csr_pkg::xlen_t m_mepc, m_mcause, m_mtval; // mcause in read form

  csr_file_top i_dut (.*);

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  function automatic csr_pkg::xlen_t next_rand();
    return $random(seed);
  endfunction

  function automatic csr_pkg::xlen_t model_read(csr_pkg::csr_addr_t addr);
    case (addr)
      csr_pkg::CSR_MSTATUS: return 32'h1800 | ({31'b0, m_mie} << 3) | ({31'b0, m_mpie} << 7);
      csr_pkg::CSR_MEPC:    return m_mepc;
      csr_pkg::CSR_MCAUSE:  return m_mcause;
      csr_pkg::CSR_MTVAL:   return m_mtval;
      default:              return '0;
    endcase
  endfunction

  function automatic void model_store(csr_pkg::csr_addr_t addr, csr_pkg::xlen_t v);
    case (addr)
      csr_pkg::CSR_MSTATUS: begin
        m_mie  = v[3];
        m_mpie = v[7];
      end
      csr_pkg::CSR_MEPC:   m_mepc   = v & 32'hFFFF_FFFE;
      csr_pkg::CSR_MCAUSE: m_mcause = v & 32'h8000_001F; // flag and code only
      csr_pkg::CSR_MTVAL:  m_mtval  = v;
      default: ;
    endcase
  endfunction

  function automatic csr_pkg::xlen_t resolve(csr_pkg::csr_op_e op, csr_pkg::xlen_t wd,
                                             csr_pkg::xlen_t old);
    case (op)
      csr_pkg::CSR_OP_WRITE: return wd;
      csr_pkg::CSR_OP_SET:   return wd | old;
      csr_pkg::CSR_OP_CLEAR: return ~wd & old;
      default:               return old;
    endcase
  endfunction

  task automatic check_value(string name, csr_pkg::xlen_t exp, csr_pkg::xlen_t act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // read request on the falling edge, sampled once settled
  task automatic read_value(csr_pkg::csr_addr_t addr, output csr_pkg::xlen_t v);
    @(negedge clk_i);
    csr_access_i  = 1'b1;
    csr_addr_i    = addr;
    csr_op_i      = csr_pkg::CSR_OP_READ;
    is_decoding_i = 1'b1;
    insn_ret_i    = 1'b0;
    #2 v = csr_rdata_o;
  endtask

  task automatic check_read(string name, csr_pkg::csr_addr_t addr, csr_pkg::xlen_t exp);
    csr_pkg::xlen_t v;
    read_value(addr, v);
    check_value(name, exp, v);
  endtask

  task automatic do_op(csr_pkg::csr_addr_t addr, csr_pkg::csr_op_e op, csr_pkg::xlen_t wd,
                       logic dec);
    csr_pkg::xlen_t nv;
    @(negedge clk_i);
    csr_access_i  = 1'b1;
    csr_addr_i    = addr;
    csr_op_i      = op;
    csr_wdata_i   = wd;
    is_decoding_i = dec;
    nv = resolve(op, wd, model_read(addr));
    if (dec && op != csr_pkg::CSR_OP_READ) model_store(addr, nv);
    @(posedge clk_i);
  endtask

  task automatic check_illegal(csr_pkg::csr_addr_t addr, csr_pkg::csr_op_e op, logic exp);
    @(negedge clk_i);
    csr_access_i  = 1'b1;
    csr_addr_i    = addr;
    csr_op_i      = op;
    is_decoding_i = 1'b0; // flag only, no state change
    #2 check_value("illegal", {31'b0, exp}, {31'b0, illegal_csr_insn_o});
  endtask

  task automatic trap_save(logic from_if);
    csr_pkg::xlen_t      pc_a, pc_b, tval;
    csr_pkg::exc_cause_t cause;
    pc_a  = next_rand() & 32'hFFFF_FFFE;
    pc_b  = next_rand() & 32'hFFFF_FFFE;
    tval  = next_rand();
    cause = csr_pkg::exc_cause_t'(next_rand());
    @(negedge clk_i);
    csr_save_cause_i = 1'b1;
    csr_save_if_i    = from_if;
    csr_save_id_i    = !from_if;
    pc_if_i          = pc_a;
    pc_id_i          = pc_b;
    csr_mcause_i     = cause;
    csr_mtval_i      = tval;
    // simultaneous mepc write, must lose
    csr_access_i  = 1'b1;
    csr_addr_i    = csr_pkg::CSR_MEPC;
    csr_op_i      = csr_pkg::CSR_OP_WRITE;
    csr_wdata_i   = next_rand();
    is_decoding_i = 1'b1;
    @(posedge clk_i);
    m_mpie   = m_mie;
    m_mie    = 1'b0;
    m_mepc   = from_if ? pc_a : pc_b;
    // code in the low bits, irq flag on top
    m_mcause = ({26'b0, cause} & 32'h0000_001F) | ({31'b0, cause[5]} << 31);
    m_mtval  = tval;
    @(negedge clk_i);
    csr_save_cause_i = 1'b0;
    csr_save_if_i    = 1'b0;
    csr_save_id_i    = 1'b0;
    csr_access_i     = 1'b0;
    #2 check_value("trap irq_en", {31'b0, m_mie}, {31'b0, m_irq_enable_o});
    check_value("trap mepc port", m_mepc, csr_mepc_o);
    check_read("trap mepc", csr_pkg::CSR_MEPC, m_mepc);
    check_read("trap mcause", csr_pkg::CSR_MCAUSE, m_mcause);
    check_read("trap mtval", csr_pkg::CSR_MTVAL, m_mtval);
    check_read("trap mstatus", csr_pkg::CSR_MSTATUS, model_read(csr_pkg::CSR_MSTATUS));
  endtask

  task automatic mret();
    @(negedge clk_i);
    csr_access_i       = 1'b0;
    csr_restore_mret_i = 1'b1;
    @(posedge clk_i);
    m_mie  = m_mpie;
    m_mpie = 1'b1;
    @(negedge clk_i);
    csr_restore_mret_i = 1'b0;
    #2 check_value("mret irq_en", {31'b0, m_mie}, {31'b0, m_irq_enable_o});
    check_read("mret mstatus", csr_pkg::CSR_MSTATUS, model_read(csr_pkg::CSR_MSTATUS));
  endtask

  ////////////////////////////////////////////////////
  // counter helpers
  ////////////////////////////////////////////////////

  task automatic cycle_delta(string name, int unsigned n, csr_pkg::xlen_t exp);
    csr_pkg::xlen_t a, b;
    read_value(csr_pkg::CSR_MCYCLE, a);
    repeat (n - 1) @(negedge clk_i);
    read_value(csr_pkg::CSR_MCYCLE, b);
    check_value(name, exp, b - a);
  endtask

  task automatic instret_delta(string name, int unsigned n, logic inhibited);
    csr_pkg::xlen_t a, b, cnt, rnd;
    cnt = '0;
    read_value(csr_pkg::CSR_MINSTRET, a);
    for (int i = 0; i < n; i++) begin
      @(negedge clk_i);
      rnd        = next_rand();
      insn_ret_i = rnd[0];
      cnt += {31'b0, insn_ret_i};
    end
    read_value(csr_pkg::CSR_MINSTRET, b);
    check_value(name, inhibited ? 32'h0 : cnt, b - a);
  endtask

  ////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////

  initial begin
    csr_pkg::xlen_t     r;
    csr_pkg::csr_addr_t addr;
    rst_ni = 1'b0;
    core_id_i = 4'hA;
    cluster_id_i = 6'h15;
    csr_access_i = 1'b0;
    is_decoding_i = 1'b0;
    csr_addr_i = '0;
    csr_wdata_i = '0;
    csr_op_i = csr_pkg::CSR_OP_READ;
    pc_if_i = '0;
    pc_id_i = '0;
    csr_save_if_i = 1'b0;
    csr_save_id_i = 1'b0;
    csr_save_cause_i = 1'b0;
    csr_restore_mret_i = 1'b0;
    csr_mcause_i = '0;
    csr_mtval_i = '0;
    csr_mtvec_i = 32'h0000_1C01;
    insn_ret_i = 1'b0;
    {m_mie, m_mpie, m_mepc, m_mcause, m_mtval} = '0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i) rst_ni = 1'b1;

    // reset values and constants
    check_value("reset irq_en", 32'h0, {31'b0, m_irq_enable_o});
    check_read("reset mstatus", csr_pkg::CSR_MSTATUS, 32'h0000_1800);
    check_read("reset mepc", csr_pkg::CSR_MEPC, 32'h0);
    check_read("reset mcause", csr_pkg::CSR_MCAUSE, 32'h0);
    check_read("reset mtval", csr_pkg::CSR_MTVAL, 32'h0);
    check_read("misa", csr_pkg::CSR_MISA, 32'h4000_1104); // mxl=1, M, I, C
    check_read("mhartid", csr_pkg::CSR_MHARTID, (32'h15 << 5) | 32'hA);
    check_read("mtvec", csr_pkg::CSR_MTVEC, 32'h0000_1C01);

    // random ops on the trap registers
    for (int i = 0; i < 48; i++) begin
      r = next_rand();
      case (r[1:0])
        2'd0:    addr = csr_pkg::CSR_MTVAL;
        2'd1:    addr = csr_pkg::CSR_MEPC;
        2'd2:    addr = csr_pkg::CSR_MCAUSE;
        default: addr = csr_pkg::CSR_MSTATUS;
      endcase
      do_op(addr, csr_pkg::csr_op_e'(r[3:2]), next_rand(), r[6:4] != 3'd0);
      check_read("random op", addr, model_read(addr));
    end

    // illegal access
    check_illegal(12'h7C0, csr_pkg::CSR_OP_READ, 1'b1);
    check_illegal(csr_pkg::CSR_MHARTID, csr_pkg::CSR_OP_WRITE, 1'b1);
    check_illegal(csr_pkg::CSR_MHARTID, csr_pkg::CSR_OP_SET, 1'b1);
    check_illegal(csr_pkg::CSR_MHARTID, csr_pkg::CSR_OP_CLEAR, 1'b1);
    check_illegal(csr_pkg::CSR_MHARTID, csr_pkg::CSR_OP_READ, 1'b0);
    check_illegal(csr_pkg::CSR_MEPC, csr_pkg::CSR_OP_WRITE, 1'b0);
    check_illegal(csr_pkg::CSR_MCYCLEH, csr_pkg::CSR_OP_SET, 1'b0);

    // trap save and mret
    do_op(csr_pkg::CSR_MSTATUS, csr_pkg::CSR_OP_WRITE, 32'h8, 1'b1);
    trap_save(1'b1);
    do_op(csr_pkg::CSR_MSTATUS, csr_pkg::CSR_OP_WRITE, 32'h8, 1'b1);
    trap_save(1'b0);
    mret();

    // counters
    cycle_delta("mcycle delta", 9, 32'd9);
    instret_delta("minstret delta", 20, 1'b0);
    do_op(csr_pkg::CSR_MCOUNTINHIBIT, csr_pkg::CSR_OP_WRITE, 32'h7, 1'b1);
    check_read("mcountinhibit", csr_pkg::CSR_MCOUNTINHIBIT, 32'hFFFF_FFFD);
    cycle_delta("mcycle frozen", 7, 32'd0);
    instret_delta("minstret frozen", 12, 1'b1);
    do_op(csr_pkg::CSR_MCOUNTINHIBIT, csr_pkg::CSR_OP_WRITE, 32'h0, 1'b1);
    do_op(csr_pkg::CSR_MCYCLEH, csr_pkg::CSR_OP_WRITE, 32'h0, 1'b1);
    do_op(csr_pkg::CSR_MCYCLE, csr_pkg::CSR_OP_WRITE, 32'hFFFF_FFFF, 1'b1);
    check_read("mcycleh before carry", csr_pkg::CSR_MCYCLEH, 32'h0);
    check_read("mcycleh after carry", csr_pkg::CSR_MCYCLEH, 32'h1);

    @(negedge clk_i) csr_access_i = 1'b0;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("timeout after %0d cycles, stimulus did not finish", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* sim/csr_file_checker.sv */
/*
 * concurrent checks on the CSR file top level
 */
`timescale 1ns/100ps

module csr_file_checker (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              csr_access_i,
  input logic              illegal_csr_insn_o,
  input csr_pkg::xlen_t    csr_mepc_i,
  input logic              csr_save_cause_i,
  input logic              m_irq_enable_i,
  input csr_pkg::counter_t mcycle_i,
  input csr_pkg::xlen_t    mcountinhibit_i,
  input logic              mcycle_we_i
);

  //////////////////////////////////////////////////
  // access port
  //////////////////////////////////////////////////

  // no request, no illegal flag
  illegal_needs_access: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !csr_access_i |-> !illegal_csr_insn_o
  ) else $error("illegal flag raised without a csr access");

  //////////////////////////////////////////////////
  // trap state
  //////////////////////////////////////////////////

  mepc_aligned: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !csr_mepc_i[0]
  ) else $error("mepc bit 0 is set");

  // handler runs with irqs off
  save_drops_irq: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    csr_save_cause_i |=> !m_irq_enable_i
  ) else $error("irq enable still high after a trap save");

  //////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////

  mcycle_counts: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (!mcountinhibit_i[csr_pkg::CNT_MCYCLE] && !mcycle_we_i)
      |=> (mcycle_i[31:0] == $past(mcycle_i[31:0]) + 32'd1)
  ) else $error("mcycle low word did not advance by one");

endmodule

bind csr_file_top csr_file_checker i_checker (
  .clk_i              (clk_i),
  .rst_ni             (rst_ni),
  .csr_access_i       (csr_access_i),
  .illegal_csr_insn_o (illegal_csr_insn_o),
  .csr_mepc_i         (csr_mepc_o),
  .csr_save_cause_i   (csr_save_cause_i),
  .m_irq_enable_i     (m_irq_enable_o),
  .mcycle_i           (mcycle),
  .mcountinhibit_i    (mcountinhibit),
  .mcycle_we_i        (mcycle_we)
);

/* logic/csr_file_top.sv */
/*
 * machine-mode CSR file, top level
 * joins the access decoder, trap registers and counters
 */
`timescale 1ns/100ps

module csr_file_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  // hart identity
  input  logic [3:0]          core_id_i,
  input  logic [5:0]          cluster_id_i,
  // csr access port
  input  logic                csr_access_i,
  input  csr_pkg::csr_addr_t  csr_addr_i,
  input  csr_pkg::xlen_t      csr_wdata_i,
  input  csr_pkg::csr_op_e    csr_op_i,
  input  logic                is_decoding_i,
  output csr_pkg::xlen_t      csr_rdata_o,
  output logic                illegal_csr_insn_o,
  // trap interface
  input  csr_pkg::xlen_t      pc_if_i,
  input  csr_pkg::xlen_t      pc_id_i,
  input  logic                csr_save_if_i,
  input  logic                csr_save_id_i,
  input  logic                csr_save_cause_i,
  input  logic                csr_restore_mret_i,
  input  csr_pkg::exc_cause_t csr_mcause_i,
  input  csr_pkg::xlen_t      csr_mtval_i,
  input  csr_pkg::xlen_t      csr_mtvec_i,
  output logic                m_irq_enable_o,
  output csr_pkg::xlen_t      csr_mepc_o,
  // counters
  input  logic                insn_ret_i
);

  csr_pkg::xlen_t      csr_wdata_int;
  logic                mstatus_we, mepc_we, mcause_we, mtval_we;
  logic                mcountinhibit_we;
  logic                mcycle_we, mcycleh_we, minstret_we, minstreth_we;
  logic                mstatus_mie, mstatus_mpie;
  csr_pkg::xlen_t      mepc, mtval, mcountinhibit;
  csr_pkg::exc_cause_t mcause;
  csr_pkg::counter_t   mcycle, minstret;

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  csr_access_decode i_decode (
    .csr_access_i, .csr_addr_i, .csr_wdata_i, .csr_op_i, .is_decoding_i,
    .core_id_i, .cluster_id_i, .csr_mtvec_i,
    .mstatus_mie_i (mstatus_mie), .mstatus_mpie_i (mstatus_mpie),
    .mepc_i (mepc), .mcause_i (mcause), .mtval_i (mtval),
    .mcycle_i (mcycle), .minstret_i (minstret), .mcountinhibit_i (mcountinhibit),
    .csr_rdata_o, .illegal_csr_insn_o, .csr_wdata_int_o (csr_wdata_int),
    .mstatus_we_o (mstatus_we), .mepc_we_o (mepc_we), .mcause_we_o (mcause_we),
    .mtval_we_o (mtval_we), .mcountinhibit_we_o (mcountinhibit_we),
    .mcycle_we_o (mcycle_we), .mcycleh_we_o (mcycleh_we),
    .minstret_we_o (minstret_we), .minstreth_we_o (minstreth_we)
  );

  //////////////////////////////////////////////////
  // state
  //////////////////////////////////////////////////

  csr_trap_regs i_trap (
    .clk_i, .rst_ni, .csr_wdata_int_i (csr_wdata_int),
    .mstatus_we_i (mstatus_we), .mepc_we_i (mepc_we),
    .mcause_we_i (mcause_we), .mtval_we_i (mtval_we),
    .pc_if_i, .pc_id_i, .csr_save_if_i, .csr_save_id_i,
    .csr_save_cause_i, .csr_restore_mret_i, .csr_mcause_i, .csr_mtval_i,
    .mstatus_mie_o (mstatus_mie), .mstatus_mpie_o (mstatus_mpie),
    .mepc_o (mepc), .mcause_o (mcause), .mtval_o (mtval)
  );

  csr_perf_counters i_counters (
    .clk_i, .rst_ni, .csr_wdata_int_i (csr_wdata_int),
    .mcountinhibit_we_i (mcountinhibit_we),
    .mcycle_we_i (mcycle_we), .mcycleh_we_i (mcycleh_we),
    .minstret_we_i (minstret_we), .minstreth_we_i (minstreth_we),
    .insn_ret_i,
    .mcycle_o (mcycle), .minstret_o (minstret), .mcountinhibit_o (mcountinhibit)
  );

  assign m_irq_enable_o = mstatus_mie; // to the irq controller
  assign csr_mepc_o     = mepc;        // mret target

endmodule

/* logic/csr_perf_counters.sv */
/*
 * machine counters
 * 64 bit mcycle and minstret with mcountinhibit and 32 bit word writes
 */
`timescale 1ns/100ps

module csr_perf_counters (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  csr_pkg::xlen_t    csr_wdata_int_i,
  input  logic              mcountinhibit_we_i,
  input  logic              mcycle_we_i,
  input  logic              mcycleh_we_i,
  input  logic              minstret_we_i,
  input  logic              minstreth_we_i,
  input  logic              insn_ret_i,      // one instr retired
  output csr_pkg::counter_t mcycle_o,
  output csr_pkg::counter_t minstret_o,
  output csr_pkg::xlen_t    mcountinhibit_o  // with absent counters forced
);

  csr_pkg::xlen_t    mcountinhibit_q, mcountinhibit_d;
  csr_pkg::counter_t mcycle_q, mcycle_d;
  csr_pkg::counter_t minstret_q, minstret_d;
  logic              mcycle_inc;
  logic              minstret_inc;

  // increment, then overwrite one word on a csr write
  function automatic csr_pkg::counter_t cnt_next(
    csr_pkg::counter_t cnt,
    logic              inc,
    logic              we_lo,
    logic              we_hi,
    csr_pkg::xlen_t    wdata
  );
    csr_pkg::counter_t nxt;
    nxt = inc ? cnt + 64'd1 : cnt;
    if (we_lo) begin
      nxt[31:0] = wdata;  // high word keeps the carry
    end else if (we_hi) begin
      nxt[63:32] = wdata;
    end
    return nxt;
  endfunction

  //////////////////////////////////////////////////
  // inhibit
  //////////////////////////////////////////////////

  always_comb begin
    mcountinhibit_d    = mcountinhibit_we_i ? csr_wdata_int_i : mcountinhibit_q;
    mcountinhibit_d[1] = 1'b0; // no mtime counter here
  end

  assign mcountinhibit_o = mcountinhibit_q | csr_pkg::MCOUNTINHIBIT_FORCE;

  //////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////

  assign mcycle_inc   = ~mcountinhibit_q[csr_pkg::CNT_MCYCLE];
  assign minstret_inc = insn_ret_i & ~mcountinhibit_q[csr_pkg::CNT_MINSTRET];

  assign mcycle_d   = cnt_next(mcycle_q, mcycle_inc, mcycle_we_i, mcycleh_we_i,
                               csr_wdata_int_i);
  assign minstret_d = cnt_next(minstret_q, minstret_inc, minstret_we_i, minstreth_we_i,
                               csr_wdata_int_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcountinhibit_q <= '0;
      mcycle_q        <= '0;
      minstret_q      <= '0;
    end else begin
      mcountinhibit_q <= mcountinhibit_d;
      mcycle_q        <= mcycle_d;   // every edge
      minstret_q      <= minstret_d;
    end
  end

  assign mcycle_o   = mcycle_q;
  assign minstret_o = minstret_q;

endmodule

/* logic/csr_trap_regs.sv */
/*
 * machine trap registers
 * mstatus mie/mpie, mepc, mcause, mtval with trap save and MRET restore
 */
`timescale 1ns/100ps

module csr_trap_regs (
  input  logic                clk_i,
  input  logic                rst_ni,
  // csr writes
  input  csr_pkg::xlen_t      csr_wdata_int_i,
  input  logic                mstatus_we_i,
  input  logic                mepc_we_i,
  input  logic                mcause_we_i,
  input  logic                mtval_we_i,
  // trap control
  input  csr_pkg::xlen_t      pc_if_i,
  input  csr_pkg::xlen_t      pc_id_i,
  input  logic                csr_save_if_i,
  input  logic                csr_save_id_i,
  input  logic                csr_save_cause_i,
  input  logic                csr_restore_mret_i,
  input  csr_pkg::exc_cause_t csr_mcause_i,
  input  csr_pkg::xlen_t      csr_mtval_i,
  // register values
  output logic                mstatus_mie_o,
  output logic                mstatus_mpie_o,
  output csr_pkg::xlen_t      mepc_o,
  output csr_pkg::exc_cause_t mcause_o,
  output csr_pkg::xlen_t      mtval_o
);

  logic                mie_q, mie_d;
  logic                mpie_q, mpie_d;
  csr_pkg::xlen_t      mepc_q, mepc_d;
  csr_pkg::exc_cause_t mcause_q, mcause_d;
  csr_pkg::xlen_t      mtval_q, mtval_d;
  csr_pkg::xlen_t      exception_pc;

  // if stage wins, id otherwise
  assign exception_pc = (csr_save_if_i || !csr_save_id_i) ? pc_if_i : pc_id_i;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    mie_d    = mie_q;
    mpie_d   = mpie_q;
    mepc_d   = mepc_q;
    mcause_d = mcause_q;
    mtval_d  = mtval_q;

    // plain csr writes first
    if (mstatus_we_i) begin
      mie_d  = csr_wdata_int_i[csr_pkg::MSTATUS_MIE_BIT];
      mpie_d = csr_wdata_int_i[csr_pkg::MSTATUS_MPIE_BIT];
    end
    if (mepc_we_i)   mepc_d   = {csr_wdata_int_i[31:1], 1'b0}; // halfword aligned
    if (mcause_we_i) mcause_d = {csr_wdata_int_i[31], csr_wdata_int_i[4:0]};
    if (mtval_we_i)  mtval_d  = csr_wdata_int_i;

    // trap save overrides, mret only without a save
    if (csr_save_cause_i) begin
      mpie_d   = mie_q;
      mie_d    = 1'b0;        // irqs off in handler
      mepc_d   = exception_pc;
      mcause_d = csr_mcause_i;
      mtval_d  = csr_mtval_i;
    end else if (csr_restore_mret_i) begin
      mie_d  = mpie_q;
      mpie_d = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
      mtval_q  <= '0;
    end else begin
      mie_q    <= mie_d;
      mpie_q   <= mpie_d;
      mepc_q   <= mepc_d;
      mcause_q <= mcause_d;
      mtval_q  <= mtval_d;
    end
  end

  assign mstatus_mie_o  = mie_q;
  assign mstatus_mpie_o = mpie_q;
  assign mepc_o         = mepc_q;
  assign mcause_o       = mcause_q;
  assign mtval_o        = mtval_q;

endmodule

/* logic/csr_access_decode.sv */
/*
 * CSR access decoder
 * read mux, illegal access check, set/clear resolution and write strobes
 */
`timescale 1ns/100ps

module csr_access_decode (
  // request
  input  logic               csr_access_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::xlen_t     csr_wdata_i,
  input  csr_pkg::csr_op_e   csr_op_i,
  input  logic               is_decoding_i,
  // identity
  input  logic [3:0]         core_id_i,
  input  logic [5:0]         cluster_id_i,
  input  csr_pkg::xlen_t     csr_mtvec_i,
  // trap register values
  input  logic               mstatus_mie_i,
  input  logic               mstatus_mpie_i,
  input  csr_pkg::xlen_t     mepc_i,
  input  csr_pkg::exc_cause_t mcause_i,
  input  csr_pkg::xlen_t     mtval_i,
  // counter values
  input  csr_pkg::counter_t  mcycle_i,
  input  csr_pkg::counter_t  minstret_i,
  input  csr_pkg::xlen_t     mcountinhibit_i,
  // results
  output csr_pkg::xlen_t     csr_rdata_o,
  output logic               illegal_csr_insn_o,
  output csr_pkg::xlen_t     csr_wdata_int_o,
  // write strobes, one hot
  output logic               mstatus_we_o,
  output logic               mepc_we_o,
  output logic               mcause_we_o,
  output logic               mtval_we_o,
  output logic               mcountinhibit_we_o,
  output logic               mcycle_we_o,
  output logic               mcycleh_we_o,
  output logic               minstret_we_o,
  output logic               minstreth_we_o
);

  csr_pkg::xlen_t mstatus_rd; // assembled mstatus word
  logic           csr_wreq;   // op modifies the csr
  logic           csr_we;     // qualified write
  logic           illegal_addr;
  logic           illegal_write;

  //////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////

  always_comb begin
    mstatus_rd                                          = '0;
    mstatus_rd[csr_pkg::MSTATUS_MIE_BIT]                = mstatus_mie_i;
    mstatus_rd[csr_pkg::MSTATUS_MPIE_BIT]               = mstatus_mpie_i;
    mstatus_rd[csr_pkg::MSTATUS_MPP_LSB+1 -: 2]         = csr_pkg::PRIV_LVL_M; // mpp fixed
  end

  // read mux, doubles as the implemented-address check
  always_comb begin
    csr_rdata_o  = '0;
    illegal_addr = 1'b0;
    case (csr_addr_i)
      csr_pkg::CSR_MSTATUS:       csr_rdata_o = mstatus_rd;
      csr_pkg::CSR_MISA:          csr_rdata_o = csr_pkg::MISA_VALUE;
      csr_pkg::CSR_MTVEC:         csr_rdata_o = csr_mtvec_i;
      csr_pkg::CSR_MCOUNTINHIBIT: csr_rdata_o = mcountinhibit_i;
      csr_pkg::CSR_MEPC:          csr_rdata_o = mepc_i;
      // irq flag moves up to bit 31
      csr_pkg::CSR_MCAUSE:        csr_rdata_o = {mcause_i[5], 26'b0, mcause_i[4:0]};
      csr_pkg::CSR_MTVAL:         csr_rdata_o = mtval_i;
      csr_pkg::CSR_MCYCLE:        csr_rdata_o = mcycle_i[31:0];
      csr_pkg::CSR_MCYCLEH:       csr_rdata_o = mcycle_i[63:32];
      csr_pkg::CSR_MINSTRET:      csr_rdata_o = minstret_i[31:0];
      csr_pkg::CSR_MINSTRETH:     csr_rdata_o = minstret_i[63:32];
      csr_pkg::CSR_MHARTID:       csr_rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
      default:                    illegal_addr = 1'b1; // not implemented
    endcase
  end

  //////////////////////////////////////////////////
  // write data resolution
  //////////////////////////////////////////////////

  always_comb begin
    csr_wreq        = 1'b1;
    csr_wdata_int_o = csr_wdata_i;
    case (csr_op_i)
      csr_pkg::CSR_OP_WRITE: csr_wdata_int_o = csr_wdata_i;
      csr_pkg::CSR_OP_SET:   csr_wdata_int_o = csr_wdata_i | csr_rdata_o;
      csr_pkg::CSR_OP_CLEAR: csr_wdata_int_o = ~csr_wdata_i & csr_rdata_o;
      csr_pkg::CSR_OP_READ:  csr_wreq = 1'b0; // no side effect
      default:               csr_wreq = 1'b0;
    endcase
  end

  // write only while decoding a real csr access
  assign csr_we = csr_wreq & csr_access_i & is_decoding_i;

  //////////////////////////////////////////////////
  // illegal check
  //////////////////////////////////////////////////

  // [11:10] == 2'b11 marks read-only space
  assign illegal_write      = (csr_addr_i[11:10] == 2'b11) & csr_wreq;
  assign illegal_csr_insn_o = csr_access_i & (illegal_addr | illegal_write);

  //////////////////////////////////////////////////
  // strobes
  //////////////////////////////////////////////////

  always_comb begin
    mstatus_we_o       = 1'b0;
    mepc_we_o          = 1'b0;
    mcause_we_o        = 1'b0;
    mtval_we_o         = 1'b0;
    mcountinhibit_we_o = 1'b0;
    mcycle_we_o        = 1'b0;
    mcycleh_we_o       = 1'b0;
    minstret_we_o      = 1'b0;
    minstreth_we_o     = 1'b0;
    case (csr_addr_i)
      csr_pkg::CSR_MSTATUS:       mstatus_we_o       = csr_we;
      csr_pkg::CSR_MEPC:          mepc_we_o          = csr_we;
      csr_pkg::CSR_MCAUSE:        mcause_we_o        = csr_we;
      csr_pkg::CSR_MTVAL:         mtval_we_o         = csr_we;
      csr_pkg::CSR_MCOUNTINHIBIT: mcountinhibit_we_o = csr_we;
      csr_pkg::CSR_MCYCLE:        mcycle_we_o        = csr_we;
      csr_pkg::CSR_MCYCLEH:       mcycleh_we_o       = csr_we;
      csr_pkg::CSR_MINSTRET:      minstret_we_o      = csr_we;
      csr_pkg::CSR_MINSTRETH:     minstreth_we_o     = csr_we;
      default: ; // read only or absent, misa/mtvec writes dropped
    endcase
  end

endmodule

/* logic/csr_pkg.sv */
/*
 * machine-mode CSR file definitions
 * data types, CSR addresses, operation codes and mstatus/mcountinhibit fields
 */
package csr_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned CSR_ADDR_W = 12;
  localparam int unsigned CNT_W      = 64; // mcycle / minstret
  localparam int unsigned CAUSE_W    = 6;  // irq flag + 5 bit code

  typedef logic [XLEN-1:0]       xlen_t;      // data word, pc, trap value
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [CNT_W-1:0]      counter_t;
  typedef logic [CAUSE_W-1:0]    exc_cause_t; // [5] irq, [4:0] code

  // csr instruction flavour
  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  //////////////////////////////////////////////////
  // implemented addresses
  //////////////////////////////////////////////////

  localparam csr_addr_t CSR_MSTATUS       = 12'h300;
  localparam csr_addr_t CSR_MISA          = 12'h301;
  localparam csr_addr_t CSR_MTVEC         = 12'h305; // read through only
  localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
  localparam csr_addr_t CSR_MEPC          = 12'h341;
  localparam csr_addr_t CSR_MCAUSE        = 12'h342;
  localparam csr_addr_t CSR_MTVAL         = 12'h343;
  localparam csr_addr_t CSR_MCYCLE        = 12'hB00;
  localparam csr_addr_t CSR_MINSTRET      = 12'hB02;
  localparam csr_addr_t CSR_MCYCLEH       = 12'hB80;
  localparam csr_addr_t CSR_MINSTRETH     = 12'hB82;
  localparam csr_addr_t CSR_MHARTID       = 12'hF14; // read only range

  //////////////////////////////////////////////////
  // fields
  //////////////////////////////////////////////////

  // mstatus bit positions
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam int unsigned MSTATUS_MPP_LSB  = 11; // mpp is [12:11]

  localparam logic [1:0] PRIV_LVL_M = 2'd3; // only machine mode

  // misa, fixed RV32IMC
  localparam xlen_t MISA_VALUE =
      (xlen_t'(1) << 30)  // mxl = 1, 32 bit
    | (xlen_t'(1) << 12)  // M
    | (xlen_t'(1) <<  8)  // I
    | (xlen_t'(1) <<  2); // C

  // counters 3..31 absent, always inhibited
  localparam xlen_t MCOUNTINHIBIT_FORCE = {29'h1FFF_FFFF, 3'b000};

  // bit index inside mcountinhibit
  localparam int unsigned CNT_MCYCLE   = 0;
  localparam int unsigned CNT_MINSTRET = 2;

endpackage
